/* command_decoder.sv */
`timescale 1ns/1ps
`default_nettype none

// turns host bytes into a power-up strobe and the go-home level
module command_decoder (
  input  logic                    clk,
  input  logic                    rst,
  input  tdc_link_pkg::rx_frame_t frame,
  output logic                    start,
  output logic                    go_home
);

  import tdc_link_pkg::*;

  logic is_power_up;
  logic is_go_home;

  assign is_power_up = frame.valid && (frame.data == cmd_power_up);
  assign is_go_home  = frame.valid && (frame.data == cmd_go_home);

  // one-cycle start pulse, registered
  always_ff @(posedge clk) begin
    if (rst) begin
      start <= 1'b0;
    end else begin
      start <= is_power_up;
    end
  end

  // go-home latch
  // "h" sets it, a new power-up clears it, anything else leaves it alone
  always_ff @(posedge clk) begin
    if (rst) begin
      go_home <= 1'b0;
    end else if (is_go_home) begin
      go_home <= 1'b1;
    end else if (is_power_up) begin
      go_home <= 1'b0;
    end
  end

endmodule

`default_nettype wire

/* run_sim.sh */
#!/bin/sh
# build and run the tdc controller testbench with verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal \
  --top-module tb_tdc_control_top \
  -f tdc_control_top.f \
  -o sim_tdc_control

status=0
./obj_dir/sim_tdc_control > sim.log 2>&1 || status=$?
cat sim.log

if grep -q "Testbench failed" sim.log; then
  echo "simulation reported a failure"
  exit 1
fi

if ! grep -q "Testbench passed" sim.log; then
  echo "no result line in sim.log, simulator exit status $status"
  exit 1
fi

exit 0

/* serial_rx.sv */
`timescale 1ns/1ps
`default_nettype none

// asynchronous serial receiver, 8 data bits lsb first, one stop bit
module serial_rx #(
  parameter int unsigned clk_per_bit = 16
) (
  input  logic                    clk,
  input  logic                    rst,
  input  logic                    rx,
  output tdc_link_pkg::rx_frame_t frame
);

  import tdc_link_pkg::*;

  localparam int unsigned cnt_w = (clk_per_bit > 2) ? $clog2(clk_per_bit) : 1;

  typedef logic [cnt_w-1:0] bit_count_t;

  typedef enum logic [1:0] {
    rx_idle,
    rx_start,
    rx_data,
    rx_stop
  } rx_state_t;

  localparam bit_count_t bit_last = bit_count_t'(clk_per_bit - 1);
  localparam bit_count_t bit_half = bit_count_t'(clk_per_bit / 2 - 1);

  rx_state_t    state;
  bit_count_t   cnt;     // cycles into the current bit
  logic [2:0]   idx;     // data bit index
  serial_byte_t shift_q; // collected data bits

  logic rx_meta;
  logic rx_sync;
  logic rx_prev;
  logic fall;
  logic bit_end;

  // two-flop synchronizer plus one more stage for edge detect
  // line idles high so reset to 1
  always_ff @(posedge clk) begin
    if (rst) begin
      rx_meta <= 1'b1;
      rx_sync <= 1'b1;
      rx_prev <= 1'b1;
    end else begin
      rx_meta <= rx;
      rx_sync <= rx_meta;
      rx_prev <= rx_sync;
    end
  end

  assign fall    = rx_prev & ~rx_sync;
  assign bit_end = (cnt == bit_last); // middle of a data or stop bit

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= rx_idle;
      cnt   <= '0;
      idx   <= '0;
    end else begin
      case (state)
        rx_idle: begin
          cnt <= '0;
          if (fall) state <= rx_start;
        end
        rx_start: begin
          if (cnt == bit_half) begin
            // start bit must still be low at mid-bit, else it was a glitch
            cnt   <= '0;
            idx   <= '0;
            state <= rx_sync ? rx_idle : rx_data;
          end else begin
            cnt <= cnt + 1'b1;
          end
        end
        rx_data: begin
          if (bit_end) begin
            cnt <= '0;
            idx <= idx + 1'b1;
            if (idx == 3'd7) state <= rx_stop;
          end else begin
            cnt <= cnt + 1'b1;
          end
        end
        rx_stop: begin
          if (bit_end) begin
            cnt   <= '0;
            state <= rx_idle; // bad stop bit just falls through here
          end else begin
            cnt <= cnt + 1'b1;
          end
        end
        default: state <= rx_idle;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state == rx_data && bit_end) shift_q <= {rx_sync, shift_q[7:1]}; // lsb first
  end

  // strobe in the cycle the stop bit is sampled high
  assign frame = '{data: shift_q, valid: (state == rx_stop) && bit_end && rx_sync};

endmodule

`default_nettype wire

/* tb_clock_gen.sv */
`timescale 1ns/1ps
`default_nettype none

// free-running clock for the testbench
module tb_clock_gen #(
  parameter int unsigned period_ns = 20
) (
  output logic clk
);

  initial begin
    clk = 1'b0;
    forever begin
      #(period_ns / 2) clk = ~clk; // half period high, half low
    end
  end

endmodule

`default_nettype wire

/* tb_tdc_control_top.sv */
`timescale 1ns/1ps
`default_nettype none

// random-stimulus testbench for the tdc bank controller
module tb_tdc_control_top;

  import tdc_link_pkg::*;
  import tdc_seq_pkg::*;

  localparam int clk_per_bit = 16;
  localparam int boot_cycles = 200;
  localparam int reset_gap   = 40;

  localparam int n_random   = 48;
  localparam int n_ignored  = 16;
  localparam int n_restarts = 3;
  localparam int n_frames   = 1 + 4 + n_random + n_ignored + 2 * n_restarts;

  localparam int min_idle       = 6; // line idle after a frame before checking
  localparam int frame_cycles   = 10 * clk_per_bit;
  localparam int frame_slot     = frame_cycles + min_idle + 15;
  localparam int seq_cycles     = boot_cycles + (int'(tdc_channels) + 1) * reset_gap + 8;
  localparam int timeout_cycles = n_frames * frame_slot + n_restarts * 256
                                  + 6 * seq_cycles + 2000;

  logic      clk;
  logic      rst;
  logic      serial_in;
  logic      tdc_enable;
  tdc_mask_t tdc_soft_reset;
  logic      go_home;

  logic [31:0] lfsr_state;
  logic        model_go_home;   // expected latch level
  int          expected_starts; // accepted power-up commands so far

  // state kept by the monitor process
  int   cycle             = 0;
  int   e0                = 0; // cycle of the latest enable rise
  logic sched_valid       = 1'b0;
  logic prev_enable       = 1'b0;
  int   rise_count        = 0;
  int   pulse_total       = 0;
  int   pulses_since_rise = 0;

  tb_clock_gen #(
    .period_ns(20)
  ) clk0 (
    .clk(clk)
  );

  tdc_control_top #(
    .clk_per_bit(clk_per_bit),
    .boot_cycles(boot_cycles),
    .reset_gap  (reset_gap)
  ) dut0 (
    .clk           (clk),
    .rst           (rst),
    .serial_in     (serial_in),
    .tdc_enable    (tdc_enable),
    .tdc_soft_reset(tdc_soft_reset),
    .go_home       (go_home)
  );

  // x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    logic fb;
    fb = s[31] ^ s[21] ^ s[1] ^ s[0];
    return {s[30:0], fb};
  endfunction

  task automatic draw_bits(input int n, output logic [31:0] value);
    value = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_state = lfsr_next(lfsr_state);
      value[i]   = lfsr_state[0]; // one step per bit taken
    end
  endtask

  task automatic stop_on_failure(input string reason);
    $display("%s", reason);
    $display("Testbench failed");
    $fatal(1, "stopping at the first error");
  endtask

  task automatic check_equal(input logic [31:0] actual, input logic [31:0] expected,
                             input string what);
    if (actual !== expected) begin
      stop_on_failure($sformatf("[FAIL] %0t ns: %s is %0h, expected %0h",
                                $time, what, actual, expected));
    end
  endtask

  task automatic drive_bit(input logic b);
    @(negedge clk);
    serial_in = b;
    repeat (clk_per_bit - 1) @(negedge clk);
  endtask

  task automatic hold_idle(input int n);
    @(negedge clk);
    serial_in = 1'b1;
    repeat (n - 1) @(negedge clk);
  endtask

  // start bit, 8 data bits lsb first, stop bit
  task automatic send_frame(input serial_byte_t data, input logic bad_stop);
    drive_bit(1'b0);
    for (int i = 0; i < 8; i++) begin
      drive_bit(data[i]);
    end
    drive_bit(~bad_stop);
  endtask

  task automatic send_and_check(input serial_byte_t data, input logic bad_stop);
    logic [31:0] idle_extra;
    send_frame(data, bad_stop);
    if (!bad_stop) begin
      if (data == cmd_go_home) begin
        model_go_home = 1'b1;
      end else if (data == cmd_power_up) begin
        model_go_home   = 1'b0;
        expected_starts = expected_starts + 1;
      end
    end
    draw_bits(4, idle_extra);
    hold_idle(min_idle + int'(idle_extra));
    check_equal(32'(go_home), 32'(model_go_home), "go_home after frame");
    check_equal(32'(rise_count), 32'(expected_starts), "tdc_enable rise count");
  endtask

  // kind 0 is go-home, 1 power-up, 2 another byte and 3 a bad stop bit
  task automatic send_random_frame(input logic commands_allowed);
    logic [31:0]  kind;
    logic [31:0]  bits;
    serial_byte_t other;
    draw_bits(2, kind);
    if (!commands_allowed) kind = 32'd2 + {31'd0, kind[0]};
    draw_bits(8, bits);
    other = serial_byte_t'(bits);
    if (other == cmd_power_up || other == cmd_go_home) other = other ^ 8'h01;
    case (kind[1:0])
      2'd0: send_and_check(cmd_go_home, 1'b0);
      2'd1: send_and_check(cmd_power_up, 1'b0);
      2'd2: send_and_check(other, 1'b0);
      default: begin
        draw_bits(1, bits);
        send_and_check(bits[0] ? cmd_power_up : other, 1'b1);
      end
    endcase
  endtask

  task automatic wait_for_sequence();
    repeat (seq_cycles) @(negedge clk); // whole schedule plus trailing gap
  endtask

  // outputs are sampled on the falling edge
  always @(negedge clk) begin : monitor
    int        offset;
    tdc_mask_t expected_soft;
    cycle = cycle + 1;
    if (cycle > timeout_cycles) begin
      stop_on_failure($sformatf("timeout: the run did not finish within %0d clock cycles",
                                timeout_cycles));
    end
    if (!rst) begin
      if (tdc_enable && !prev_enable) begin
        e0                = cycle;
        sched_valid       = 1'b1;
        rise_count        = rise_count + 1;
        pulses_since_rise = 0;
      end
      if (!tdc_enable && !prev_enable && rise_count > 0) begin
        stop_on_failure("tdc_enable stayed low for more than one cycle after power-up");
      end
      if (!tdc_enable) sched_valid = 1'b0; // a restart drops the old schedule
      expected_soft = '0;
      if (sched_valid) begin
        offset = cycle - e0;
        for (int k = 0; k < int'(tdc_channels); k++) begin
          if (offset == boot_cycles + (k + 1) * reset_gap) expected_soft[k] = 1'b1;
        end
      end
      if (!$onehot0(tdc_soft_reset)) begin
        stop_on_failure("tdc_soft_reset had more than one bit high in one cycle");
      end
      check_equal(32'(tdc_soft_reset), 32'(expected_soft), "tdc_soft_reset");
      if (tdc_soft_reset != '0) begin
        pulse_total       = pulse_total + 1;
        pulses_since_rise = pulses_since_rise + 1;
      end
      prev_enable = tdc_enable;
    end
  end

  initial begin : main
    logic [31:0] delay;
    int          pulses_before;
    int          rises_before;
    lfsr_state      = 32'h19683b58;
    rst             = 1'b1;
    serial_in       = 1'b1; // line idles high
    model_go_home   = 1'b0;
    expected_starts = 0;
    repeat (2) @(posedge clk); // two reset cycles
    @(negedge clk);
    rst = 1'b0;
    @(negedge clk);

    check_equal(32'(tdc_enable), 32'd0, "tdc_enable after reset");
    check_equal(32'(tdc_soft_reset), 32'd0, "tdc_soft_reset after reset");
    check_equal(32'(go_home), 32'd0, "go_home after reset");

    // one full power-up schedule
    pulses_before = pulse_total;
    send_and_check(cmd_power_up, 1'b0);
    wait_for_sequence();
    check_equal(32'(pulse_total - pulses_before), 32'(tdc_channels), "pulses in one sequence");
    check_equal(32'(tdc_enable), 32'd1, "tdc_enable after the sequence");

    // directed go-home latch frames
    send_and_check(cmd_go_home, 1'b0);
    send_and_check(8'h78, 1'b0);        // "x" leaves it set
    send_and_check(cmd_power_up, 1'b1); // dropped frame
    send_and_check(cmd_power_up, 1'b0); // clears and starts
    wait_for_sequence();

    for (int i = 0; i < n_random; i++) begin
      send_random_frame(1'b1);
    end
    wait_for_sequence();

    // unknown bytes and bad frames must leave everything alone
    rises_before  = rise_count;
    pulses_before = pulse_total;
    for (int i = 0; i < n_ignored; i++) begin
      send_random_frame(1'b0);
    end
    check_equal(32'(rise_count), 32'(rises_before), "rises during ignored frames");
    check_equal(32'(pulse_total), 32'(pulses_before), "pulses during ignored frames");

    // restart in the middle of a running sequence
    for (int r = 0; r < n_restarts; r++) begin
      send_and_check(cmd_power_up, 1'b0);
      draw_bits(8, delay);
      hold_idle(1 + int'(delay));
      send_and_check(cmd_power_up, 1'b0);
      wait_for_sequence();
      check_equal(32'(pulses_since_rise), 32'(tdc_channels), "pulses after restart");
    end

    $display("Testbench passed");
    $finish;
  end

endmodule

`default_nettype wire

/* tdc_control_top.f */
tdc_link_pkg.sv
tdc_seq_pkg.sv
serial_rx.sv
command_decoder.sv
tdc_power_sequencer.sv
tdc_control_top.sv
tb_clock_gen.sv
tb_tdc_control_top.sv

/* tdc_control_top.sv */
`timescale 1ns/1ps
`default_nettype none

// tdc bank controller top
// serial commands in, tdc enable, soft resets and go-home level out
module tdc_control_top #(
  parameter int unsigned clk_per_bit = 16,
  parameter int unsigned boot_cycles = 200,
  parameter int unsigned reset_gap   = 40
) (
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   serial_in,
  output logic                   tdc_enable,
  output tdc_seq_pkg::tdc_mask_t tdc_soft_reset,
  output logic                   go_home
);

  import tdc_link_pkg::*;
  import tdc_seq_pkg::*;

  rx_frame_t rx_frame; // received byte and its strobe
  logic      start;    // power-up command seen
  tdc_ctrl_t tdc_ctrl;

  serial_rx #(
    .clk_per_bit(clk_per_bit)
  ) rx0 (
    .clk  (clk),
    .rst  (rst),
    .rx   (serial_in),
    .frame(rx_frame)
  );

  command_decoder dec0 (
    .clk    (clk),
    .rst    (rst),
    .frame  (rx_frame),
    .start  (start),
    .go_home(go_home)
  );

  tdc_power_sequencer #(
    .boot_cycles(boot_cycles),
    .reset_gap  (reset_gap)
  ) seq0 (
    .clk  (clk),
    .rst  (rst),
    .start(start),
    .ctrl (tdc_ctrl)
  );

  // one enable shared by the bank, soft resets per chip
  assign tdc_enable     = tdc_ctrl.enable;
  assign tdc_soft_reset = tdc_ctrl.soft_reset;

endmodule

`default_nettype wire

/* tdc_link_pkg.sv */
`default_nettype none

// serial link types and host command codes
package tdc_link_pkg;

  // one character as it comes off the serial line
  typedef logic [7:0] serial_byte_t;

  // host commands are single ascii characters
  localparam serial_byte_t cmd_power_up = 8'h64; // "d"
  localparam serial_byte_t cmd_go_home  = 8'h68; // "h"

  // receiver output bundle
  // valid is high for one cycle, data is good in that cycle
  typedef struct packed {
    serial_byte_t data;
    logic         valid;
  } rx_frame_t;

endpackage

`default_nettype wire

/* tdc_power_sequencer.sv */
`timescale 1ns/1ps
`default_nettype none

// tdc power-up sequence
// enable low for one cycle, then high, boot wait, then one soft-reset
// pulse per chip spaced reset_gap apart so the chips start out of step
module tdc_power_sequencer #(
  parameter int unsigned boot_cycles = 200,
  parameter int unsigned reset_gap   = 40
) (
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   start,
  output tdc_seq_pkg::tdc_ctrl_t ctrl
);

  import tdc_seq_pkg::*;

  localparam int unsigned chan_w = $clog2(tdc_channels + 1);

  typedef logic [chan_w-1:0] chan_idx_t;

  localparam seq_count_t boot_last = seq_count_t'(boot_cycles);
  localparam seq_count_t gap_last  = seq_count_t'(reset_gap - 1);
  localparam chan_idx_t  chan_done = chan_idx_t'(tdc_channels);

  seq_state_t state_d, state_q;
  tdc_ctrl_t  ctrl_d, ctrl_q;
  seq_count_t count_d, count_q; // boot wait
  seq_count_t gap_d, gap_q;     // spacing between pulses
  chan_idx_t  chan_d, chan_q;   // next chip to reset

  always_comb begin
    state_d           = state_q;
    ctrl_d.enable     = ctrl_q.enable;
    ctrl_d.soft_reset = '0; // pulses last a single cycle
    count_d           = count_q;
    gap_d             = gap_q;
    chan_d            = chan_q;

    case (state_q)
      seq_idle: begin
        // hold enable where the last sequence left it
      end

      seq_boot: begin
        ctrl_d.enable = 1'b1;
        if (count_q == boot_last) begin
          state_d = seq_reset;
          gap_d   = '0;
          chan_d  = '0;
        end else begin
          count_d = count_q + 1'b1;
        end
      end

      seq_reset: begin
        if (gap_q == gap_last) begin
          gap_d = '0;
          if (chan_q == chan_done) begin
            state_d = seq_idle; // trailing gap after the last chip is over
          end else begin
            ctrl_d.soft_reset = tdc_mask_t'(1) << chan_q;
            chan_d            = chan_q + 1'b1;
          end
        end else begin
          gap_d = gap_q + 1'b1;
        end
      end

      default: state_d = seq_idle;
    endcase

    // a new power-up command restarts from the enable-low cycle
    if (start) begin
      state_d           = seq_boot;
      ctrl_d.enable     = 1'b0;
      ctrl_d.soft_reset = '0;
      count_d           = '0;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q <= seq_idle;
      ctrl_q  <= '0;
      count_q <= '0;
      gap_q   <= '0;
      chan_q  <= '0;
    end else begin
      state_q <= state_d;
      ctrl_q  <= ctrl_d;
      count_q <= count_d;
      gap_q   <= gap_d;
      chan_q  <= chan_d;
    end
  end

  assign ctrl = ctrl_q;

endmodule

`default_nettype wire

/* tdc_seq_pkg.sv */
`default_nettype none

// types for the tdc power-up and soft-reset sequencing
package tdc_seq_pkg;

  // number of tdc chips on the board
  localparam int unsigned tdc_channels = 6;

  // one bit per chip, bit k goes to chip k
  typedef logic [tdc_channels-1:0] tdc_mask_t;

  // cycle counter, 20 bits covers about 20 ms at 50 MHz
  typedef logic [19:0] seq_count_t;

  // sequencer states
  typedef enum logic [1:0] {
    seq_idle,  // nothing running, enable holds its level
    seq_boot,  // enable high, waiting for the chips to boot
    seq_reset  // walking the soft-reset pulses across the chips
  } seq_state_t;

  // everything that goes out to the chips
  typedef struct packed {
    logic      enable;     // shared by all six chips
    tdc_mask_t soft_reset; // one-cycle pulses, at most one bit high
  } tdc_ctrl_t;

endpackage

`default_nettype wire
